// File: Makefile
# Verilator lint, simulation and clean for the integer ALU

TOP = ialu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

obj_dir/V$(TOP): list.f design/*.sv design/*.svh test/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f list.f

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/ialu_decode.sv
// Decode stage of the integer ALU
// Request capture, unit classification and ready generation

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    op_vd,
    input  ialu_pkg::ialu_cmd_e     op_cmd,
    input  logic [`IALU_XLEN-1:0]   op1,
    input  logic [`IALU_XLEN-1:0]   op2,
    input  logic                    mdu_busy,
    output logic                    op_rdy,
    output logic                    dec_vd,
    output ialu_pkg::ialu_cmd_e     dec_cmd,
    output ialu_pkg::ialu_unit_e    dec_unit,
    output logic [`IALU_XLEN-1:0]   dec_op1,
    output logic [`IALU_XLEN-1:0]   dec_op2
);

    import ialu_pkg::*;

    logic           accept;
    ialu_unit_e     op_unit;

    // Hold off while a multiply or divide sits in decode or runs in the MDU
    assign op_rdy = ~mdu_busy & ~(dec_vd & (dec_unit != UNIT_INT));
    assign accept = op_vd & op_rdy;

    always_comb begin
        case (op_cmd)
            CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU: op_unit = UNIT_MUL;
            CMD_DIV, CMD_DIVU, CMD_REM, CMD_REMU:     op_unit = UNIT_DIV;
            default:                                  op_unit = UNIT_INT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_vd <= 1'b0;
        end else begin
            dec_vd <= accept;           // One pulse per request
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_cmd  <= op_cmd;
            dec_unit <= op_unit;
            dec_op1  <= op1;
            dec_op2  <= op2;
        end
    end

endmodule

`default_nettype wire

// File: design/ialu_defs.svh
// Width and iteration-count macros for the integer ALU
// Word, shift amount and MDU counter sizes

`ifndef IALU_DEFS_SVH
`define IALU_DEFS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define IALU_XLEN       32      // Data word width
`define IALU_SHAMT_W    5       // Shift amount from the low bits of operand 2

// ----------------------------------------
// Iterative MDU
// ----------------------------------------
`define IALU_CNT_W      5       // Iteration counter width

// Start value of the down counter that reaches zero after 32 steps
`define IALU_ITER_LAST  31

`endif

// File: design/ialu_int_unit.sv
// Combinational integer execute unit
// Add/sub with flags, comparisons, logic operations and shifter

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_int_unit (
    input  ialu_pkg::ialu_cmd_e     dec_cmd,
    input  logic [`IALU_XLEN-1:0]   dec_op1,
    input  logic [`IALU_XLEN-1:0]   dec_op2,
    output logic [`IALU_XLEN-1:0]   int_res,
    output logic                    int_cmp
);

    import ialu_pkg::*;

    localparam int MSB = `IALU_XLEN - 1;

    logic                       sub;
    logic [`IALU_XLEN:0]        sum;        // Extra bit holds carry or borrow
    logic                       flag_c;
    logic                       flag_z;
    logic                       flag_s;
    logic                       flag_o;
    logic                       lt_s;
    logic [`IALU_SHAMT_W-1:0]   shamt;
    logic [`IALU_XLEN-1:0]      shft_res;

    // ----------------------------------------
    // Adder and flags
    // ----------------------------------------
    assign sub = (dec_cmd != CMD_ADD);      // Compares subtract too

    always_comb begin
        if (sub) begin
            sum = {1'b0, dec_op1} - {1'b0, dec_op2};
        end else begin
            sum = {1'b0, dec_op1} + {1'b0, dec_op2};
        end
    end

    assign flag_c = sum[`IALU_XLEN];        // Borrow on subtract
    assign flag_z = (sum[MSB:0] == '0);
    assign flag_s = sum[MSB];
    assign flag_o = (dec_op1[MSB] ^ dec_op2[MSB] ^ ~sub) & (sum[MSB] ^ dec_op1[MSB]);
    assign lt_s   = flag_s ^ flag_o;

    // ----------------------------------------
    // Shifter
    // ----------------------------------------
    assign shamt = dec_op2[`IALU_SHAMT_W-1:0];

    always_comb begin
        case (dec_cmd)
            CMD_SRL: shft_res = dec_op1 >> shamt;
            CMD_SRA: shft_res = $signed(dec_op1) >>> shamt;    // Sign fill
            default: shft_res = dec_op1 << shamt;
        endcase
    end

    // ----------------------------------------
    // Result mux
    // ----------------------------------------
    always_comb begin
        int_cmp = 1'b0;
        case (dec_cmd)
            CMD_ADD, CMD_SUB:          int_res = sum[MSB:0];
            CMD_AND:                   int_res = dec_op1 & dec_op2;
            CMD_OR:                    int_res = dec_op1 | dec_op2;
            CMD_XOR:                   int_res = dec_op1 ^ dec_op2;
            CMD_SLL, CMD_SRL, CMD_SRA: int_res = shft_res;
            CMD_SLT: begin
                int_cmp = lt_s;
                int_res = `IALU_XLEN'(int_cmp);
            end
            CMD_SLTU: begin
                int_cmp = flag_c;
                int_res = `IALU_XLEN'(int_cmp);
            end
            CMD_SEQ: begin
                int_cmp = flag_z;
                int_res = `IALU_XLEN'(int_cmp);
            end
            CMD_SNE: begin
                int_cmp = ~flag_z;
                int_res = `IALU_XLEN'(int_cmp);
            end
            CMD_SGE: begin
                int_cmp = ~lt_s;
                int_res = `IALU_XLEN'(int_cmp);
            end
            CMD_SGEU: begin
                int_cmp = ~flag_c;
                int_res = `IALU_XLEN'(int_cmp);
            end
            default: int_res = '0;              // MDU commands
        endcase
    end

endmodule

`default_nettype wire

// File: design/ialu_mdu.sv
// Iterative multiply/divide unit
// Shift-add multiplier and restoring divider, one bit per cycle
// IDLE/ITER/CORR state machine with sign correction

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_mdu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_vd,
    input  ialu_pkg::ialu_unit_e    dec_unit,
    input  ialu_pkg::ialu_cmd_e     dec_cmd,
    input  logic [`IALU_XLEN-1:0]   dec_op1,
    input  logic [`IALU_XLEN-1:0]   dec_op2,
    output logic                    mdu_busy,
    output logic                    mdu_done,
    output logic [`IALU_XLEN-1:0]   mdu_res
);

    import ialu_pkg::*;

    localparam int XL = `IALU_XLEN;

    mdu_state_e                 state_q;
    mdu_state_e                 state_d;
    logic [`IALU_CNT_W-1:0]     cnt_q;
    ialu_unit_e                 unit_q;
    ialu_cmd_e                  cmd_q;
    logic [2*XL-1:0]            acc_q;      // High half partial product or remainder
    logic [2*XL-1:0]            acc_d;
    logic [XL-1:0]              opb_q;      // Multiplicand or divisor magnitude
    logic                       neg_q;      // Negate final result

    logic                       start;
    logic                       div_zero;
    logic                       is_rem;
    logic                       a_sgn;
    logic                       b_sgn;
    logic                       a_neg;
    logic                       b_neg;
    logic [XL-1:0]              a_mag;
    logic [XL-1:0]              b_mag;
    logic                       last_iter;
    logic [XL:0]                mul_sum;
    logic [XL:0]                rem_sh;
    logic [XL+1:0]              div_diff;
    logic [2*XL-1:0]            prod;
    logic [XL-1:0]              corr_sel;
    logic [XL-1:0]              dz_res;

    assign start     = dec_vd & (dec_unit != UNIT_INT);
    assign div_zero  = (dec_unit == UNIT_DIV) & (dec_op2 == '0);
    assign is_rem    = (dec_cmd == CMD_REM) | (dec_cmd == CMD_REMU);
    assign last_iter = (state_q == MDU_ITER) & (cnt_q == '0);

    // ----------------------------------------
    // Operand preparation
    // ----------------------------------------
    always_comb begin
        a_sgn = 1'b0;
        b_sgn = 1'b0;
        case (dec_cmd)
            CMD_MULH, CMD_DIV, CMD_REM: begin
                a_sgn = 1'b1;
                b_sgn = 1'b1;
            end
            CMD_MULHSU: a_sgn = 1'b1;
            default: ;
        endcase
    end

    assign a_neg = a_sgn & dec_op1[XL-1];
    assign b_neg = b_sgn & dec_op2[XL-1];
    assign a_mag = a_neg ? -dec_op1 : dec_op1;
    assign b_mag = b_neg ? -dec_op2 : dec_op2;

    // ----------------------------------------
    // Iteration step
    // ----------------------------------------
    always_comb begin
        mul_sum  = {1'b0, acc_q[2*XL-1:XL]} + (acc_q[0] ? {1'b0, opb_q} : '0);
        rem_sh   = {acc_q[2*XL-1:XL], acc_q[XL-1]};        // Next dividend bit in
        div_diff = {1'b0, rem_sh} - {2'b00, opb_q};
        if (unit_q == UNIT_MUL) begin
            acc_d = {mul_sum, acc_q[XL-1:1]};
        end else if (div_diff[XL+1]) begin
            acc_d = {rem_sh[XL-1:0], acc_q[XL-2:0], 1'b0};  // Restore
        end else begin
            acc_d = {div_diff[XL-1:0], acc_q[XL-2:0], 1'b1};
        end
    end

    assign prod     = neg_q ? -acc_d : acc_d;              // Last product step
    assign corr_sel = ((cmd_q == CMD_REM) | (cmd_q == CMD_REMU)) ? acc_q[2*XL-1:XL]
                                                                : acc_q[XL-1:0];
    assign dz_res   = is_rem ? dec_op1 : '1;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            MDU_IDLE: if (start & ~div_zero) state_d = MDU_ITER;
            MDU_ITER: begin
                if (cnt_q == '0) begin
                    state_d = (unit_q == UNIT_DIV) ? MDU_CORR : MDU_IDLE;
                end
            end
            default: state_d = MDU_IDLE;                  // CORR lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MDU_IDLE;
            cnt_q   <= '0;
            unit_q  <= UNIT_INT;
        end else begin
            state_q <= state_d;
            if (start) begin
                cnt_q  <= `IALU_CNT_W'(`IALU_ITER_LAST);
                unit_q <= dec_unit;
            end else if (state_q == MDU_ITER) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_q <= {{XL{1'b0}}, a_mag};
            opb_q <= b_mag;
            neg_q <= is_rem ? a_neg : (a_neg ^ b_neg);
            cmd_q <= dec_cmd;
        end else if (state_q == MDU_ITER) begin
            acc_q <= acc_d;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    assign mdu_busy = start | (state_q != MDU_IDLE);
    assign mdu_done = (start & div_zero) | (last_iter & (unit_q == UNIT_MUL)) |
                      (state_q == MDU_CORR);

    always_comb begin
        case (state_q)
            MDU_ITER: mdu_res = (cmd_q == CMD_MUL) ? prod[XL-1:0] : prod[2*XL-1:XL];
            MDU_CORR: mdu_res = neg_q ? -corr_sel : corr_sel;
            default:  mdu_res = dz_res;                    // Divide by zero
        endcase
    end

endmodule

`default_nettype wire

// File: design/ialu_pkg.sv
// Shared enum types for the integer ALU
// Command codes, execute unit tags and MDU states

`default_nettype none

package ialu_pkg;

    typedef enum logic [4:0] {
        CMD_ADD,
        CMD_SUB,
        CMD_AND,
        CMD_OR,
        CMD_XOR,
        CMD_SLL,
        CMD_SRL,
        CMD_SRA,
        CMD_SLT,            // Signed less than
        CMD_SLTU,
        CMD_SEQ,
        CMD_SNE,
        CMD_SGE,
        CMD_SGEU,
        CMD_MUL,            // Low word of product
        CMD_MULH,
        CMD_MULHSU,
        CMD_MULHU,
        CMD_DIV,
        CMD_DIVU,
        CMD_REM,
        CMD_REMU
    } ialu_cmd_e;

    typedef enum logic [1:0] {
        UNIT_INT,           // Single-cycle integer unit
        UNIT_MUL,
        UNIT_DIV
    } ialu_unit_e;

    typedef enum logic [1:0] {
        MDU_IDLE,
        MDU_ITER,           // One bit per cycle
        MDU_CORR            // Sign fix for divide
    } mdu_state_e;

endpackage

`default_nettype wire

// File: design/ialu_result.sv
// Result stage of the integer ALU
// Source select and output registers

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_result (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_vd,
    input  ialu_pkg::ialu_unit_e    dec_unit,
    input  logic [`IALU_XLEN-1:0]   int_res,
    input  logic                    int_cmp,
    input  logic                    mdu_done,
    input  logic [`IALU_XLEN-1:0]   mdu_res,
    output logic [`IALU_XLEN-1:0]   res,
    output logic                    res_cmp,
    output logic                    res_vld
);

    import ialu_pkg::*;

    logic   int_take;

    assign int_take = dec_vd & (dec_unit == UNIT_INT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= 1'b0;
        end else begin
            res_vld <= int_take | mdu_done;     // Never both at once
        end
    end

    always_ff @(posedge clk) begin
        if (int_take | mdu_done) begin
            res     <= int_take ? int_res : mdu_res;
            res_cmp <= int_take & int_cmp;      // No compare flag from MDU
        end
    end

endmodule

`default_nettype wire

// File: design/ialu_top.sv
// Top level of the pipelined integer ALU
// Decode, integer unit, multiply/divide unit and result stage

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    op_vd,
    input  ialu_pkg::ialu_cmd_e     op_cmd,
    input  logic [`IALU_XLEN-1:0]   op1,
    input  logic [`IALU_XLEN-1:0]   op2,
    output logic                    op_rdy,
    output logic [`IALU_XLEN-1:0]   res,
    output logic                    res_cmp,
    output logic                    res_vld
);

    import ialu_pkg::*;

    logic                   dec_vd;
    ialu_cmd_e              dec_cmd;
    ialu_unit_e             dec_unit;
    logic [`IALU_XLEN-1:0]  dec_op1;
    logic [`IALU_XLEN-1:0]  dec_op2;
    logic                   mdu_busy;
    logic [`IALU_XLEN-1:0]  int_res;
    logic                   int_cmp;
    logic                   mdu_done;
    logic [`IALU_XLEN-1:0]  mdu_res;

    ialu_decode u_decode (
        .clk(clk), .rst_n(rst_n), .op_vd(op_vd), .op_cmd(op_cmd), .op1(op1), .op2(op2),
        .mdu_busy(mdu_busy), .op_rdy(op_rdy), .dec_vd(dec_vd), .dec_cmd(dec_cmd),
        .dec_unit(dec_unit), .dec_op1(dec_op1), .dec_op2(dec_op2)
    );

    ialu_int_unit u_int_unit (
        .dec_cmd(dec_cmd), .dec_op1(dec_op1), .dec_op2(dec_op2),
        .int_res(int_res), .int_cmp(int_cmp)
    );

    ialu_mdu u_mdu (
        .clk(clk), .rst_n(rst_n), .dec_vd(dec_vd), .dec_unit(dec_unit), .dec_cmd(dec_cmd),
        .dec_op1(dec_op1), .dec_op2(dec_op2), .mdu_busy(mdu_busy), .mdu_done(mdu_done),
        .mdu_res(mdu_res)
    );

    ialu_result u_result (
        .clk(clk), .rst_n(rst_n), .dec_vd(dec_vd), .dec_unit(dec_unit), .int_res(int_res),
        .int_cmp(int_cmp), .mdu_done(mdu_done), .mdu_res(mdu_res), .res(res),
        .res_cmp(res_cmp), .res_vld(res_vld)
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/ialu_pkg.sv
design/ialu_decode.sv
design/ialu_int_unit.sv
design/ialu_mdu.sv
design/ialu_result.sv
design/ialu_top.sv
test/ialu_props.sv
test/ialu_tb.sv

// File: test/ialu_props.sv
// Concurrent assertions on the MDU state machine and its outputs
// Bound into every ialu_mdu instance

`timescale 1ns/1ps
`default_nettype none

module ialu_props (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ialu_pkg::mdu_state_e    state_q,
    input  logic                    start,
    input  logic                    mdu_busy,
    input  logic                    mdu_done
);

    import ialu_pkg::*;

    logic   pend;           // Started and done not seen yet
    int     wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b0;
            wait_cnt <= 0;
        end else begin
            if (mdu_done) begin
                pend <= 1'b0;
            end else if (start) begin
                pend <= 1'b1;
            end
            wait_cnt <= (pend && !mdu_done) ? wait_cnt + 1 : 0;
        end
    end

    a_idle_to_iter: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == MDU_IDLE) |=> (state_q == MDU_IDLE || state_q == MDU_ITER))
        else $error("MDU left IDLE for a state other than ITER");

    a_corr_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == MDU_CORR) |=> (state_q == MDU_IDLE))
        else $error("MDU CORR not followed by IDLE");

    a_done_has_start: assert property (@(posedge clk) disable iff (!rst_n)
        mdu_done |-> (start || pend))
        else $error("mdu_done without a start");

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !pend)
        else $error("MDU start while an operation is outstanding");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mdu_done |=> !mdu_done)
        else $error("mdu_done longer than one cycle");

    a_done_in_time: assert property (@(posedge clk) disable iff (!rst_n)
        pend |-> (wait_cnt < 40))
        else $error("MDU start never reached done");

    a_busy_active: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q != MDU_IDLE) |-> mdu_busy)
        else $error("mdu_busy low in ITER or CORR");

endmodule

bind ialu_mdu ialu_props u_props (
    .clk(clk), .rst_n(rst_n), .state_q(state_q), .start(start),
    .mdu_busy(mdu_busy), .mdu_done(mdu_done)
);

`default_nettype wire

// File: test/ialu_tb.sv
// Testbench for the pipelined integer ALU
// Stimulus table with reference model, in-order result monitor and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "ialu_defs.svh"

module ialu_tb;

    import ialu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;           // Input skew after the rising edge
    localparam int N_CMDS       = 22;
    localparam int N_EDGE_PAIRS = 16;
    localparam int N_RAND       = 6;
    localparam int N_ENTRIES    = (N_EDGE_PAIRS + N_RAND) * N_CMDS;
    localparam int WDOG_CYCLES  = N_ENTRIES * 40 + 100;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   op_vd;
    ialu_cmd_e              op_cmd;
    logic [`IALU_XLEN-1:0]  op1;
    logic [`IALU_XLEN-1:0]  op2;
    logic                   op_rdy;
    logic [`IALU_XLEN-1:0]  res;
    logic                   res_cmp;
    logic                   res_vld;

    // ----------------------------------------
    // Stimulus table and bookkeeping
    // ----------------------------------------
    ialu_cmd_e              tbl_cmd  [N_ENTRIES];
    logic [`IALU_XLEN-1:0]  tbl_op1  [N_ENTRIES];
    logic [`IALU_XLEN-1:0]  tbl_op2  [N_ENTRIES];
    logic [`IALU_XLEN-1:0]  tbl_res  [N_ENTRIES];
    logic                   tbl_cmp  [N_ENTRIES];
    int                     acc_edge [N_ENTRIES];     // Edge number of acceptance
    int                     pending  [$];             // Accepted with result not yet seen
    int                     cyc = 0;
    int                     errors = 0;
    int                     n_checked = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ialu_top dut0 (
        .clk(clk), .rst_n(rst_n), .op_vd(op_vd), .op_cmd(op_cmd), .op1(op1), .op2(op2),
        .op_rdy(op_rdy), .res(res), .res_cmp(res_cmp), .res_vld(res_vld)
    );

    function automatic logic [31:0] edge_value(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    function automatic logic is_mdu_cmd(input ialu_cmd_e cmd);
        return (cmd == CMD_MUL) || (cmd == CMD_MULH) || (cmd == CMD_MULHSU) ||
               (cmd == CMD_MULHU) || (cmd == CMD_DIV) || (cmd == CMD_DIVU) ||
               (cmd == CMD_REM) || (cmd == CMD_REMU);
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic model_expect(input ialu_cmd_e cmd, input logic [31:0] a,
                                input logic [31:0] b, output logic [31:0] r,
                                output logic c);
        logic [63:0]        pu;
        logic signed [63:0] ps;
        logic               ovf;
        pu  = {32'b0, a} * {32'b0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);   // Most negative by -1
        r   = '0;
        c   = 1'b0;
        case (cmd)
            CMD_ADD:    r = a + b;
            CMD_SUB:    r = a - b;
            CMD_AND:    r = a & b;
            CMD_OR:     r = a | b;
            CMD_XOR:    r = a ^ b;
            CMD_SLL:    r = a << b[4:0];
            CMD_SRL:    r = a >> b[4:0];
            CMD_SRA:    r = $signed(a) >>> b[4:0];
            CMD_SLT:    c = $signed(a) < $signed(b);
            CMD_SLTU:   c = a < b;
            CMD_SEQ:    c = a == b;
            CMD_SNE:    c = a != b;
            CMD_SGE:    c = $signed(a) >= $signed(b);
            CMD_SGEU:   c = a >= b;
            CMD_MUL:    r = pu[31:0];
            CMD_MULHU:  r = pu[63:32];
            CMD_MULH: begin
                ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                r  = ps[63:32];
            end
            CMD_MULHSU: begin
                ps = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
                r  = ps[63:32];
            end
            CMD_DIV: begin
                if (b == 0) r = '1;
                else if (ovf) r = a;
                else r = $signed(a) / $signed(b);
            end
            CMD_REM: begin
                if (b == 0) r = a;
                else if (ovf) r = '0;
                else r = $signed(a) % $signed(b);
            end
            CMD_DIVU:   r = (b == 0) ? '1 : a / b;
            CMD_REMU:   r = (b == 0) ? a : a % b;
            default:    r = '0;
        endcase
        r = r | {31'b0, c};                     // Compares return 0 or 1
    endtask

    // Edge operand pairs first and random ones after, all commands in each row
    task automatic build_table();
        int             idx;
        logic [31:0]    a;
        logic [31:0]    b;
        idx = 0;
        for (int p = 0; p < N_EDGE_PAIRS + N_RAND; p++) begin
            for (int c = 0; c < N_CMDS; c++) begin
                if (p < N_EDGE_PAIRS) begin
                    a = edge_value(p / 4);
                    b = edge_value(p % 4);
                end else if (p % 3 == 0) begin
                    a = $urandom;
                    b = $urandom;
                end else if (p % 3 == 1) begin
                    a = $urandom;
                    b = $urandom % 64;          // Small divisors including zero
                end else begin
                    a = $urandom;
                    b = 32'hffff_fff0 | ($urandom & 32'hf);
                end
                tbl_cmd[idx] = ialu_cmd_e'(5'(c));
                tbl_op1[idx] = a;
                tbl_op2[idx] = b;
                model_expect(tbl_cmd[idx], a, b, tbl_res[idx], tbl_cmp[idx]);
                idx++;
            end
        end
    endtask

    // Starts just after a rising edge and ends just after the accepting edge
    task automatic apply_entry(input int i);
        op_vd  = 1'b1;
        op_cmd = tbl_cmd[i];
        op1    = tbl_op1[i];
        op2    = tbl_op2[i];
        do begin
            @(negedge clk);
        end while (!op_rdy);
        acc_edge[i] = cyc + 1;
        if (i > 0 && !is_mdu_cmd(tbl_cmd[i-1]) && acc_edge[i] != acc_edge[i-1] + 1) begin
            errors++;
            $display("FAIL %0t: entry %0d accepted %0d edges after an integer request",
                     $time, i, acc_edge[i] - acc_edge[i-1]);
        end
        @(posedge clk);
        pending.push_back(i);
        #(DRIVE_DLY);
    endtask

    task automatic check_result(input int idx);
        int lat;
        lat = cyc - acc_edge[idx] + 1;          // Counts the accepting edge
        if (res !== tbl_res[idx] || res_cmp !== tbl_cmp[idx]) begin
            errors++;
            $display("FAIL %0t: entry %0d %s op1=%h op2=%h res=%h cmp=%b, expected %h %b",
                     $time, idx, tbl_cmd[idx].name(), tbl_op1[idx], tbl_op2[idx],
                     res, res_cmp, tbl_res[idx], tbl_cmp[idx]);
        end
        if (!is_mdu_cmd(tbl_cmd[idx]) && lat != 2) begin
            errors++;
            $display("FAIL %0t: entry %0d integer latency %0d edges, expected 2",
                     $time, idx, lat);
        end
    endtask

    // ----------------------------------------
    // Result monitor in request order
    // ----------------------------------------
    always @(negedge clk) begin : monitor
        int idx;
        if (rst_n && res_vld) begin
            if (pending.size() == 0) begin
                errors++;
                $display("Unexpected res_vld at %0t with no request outstanding", $time);
            end else begin
                idx = pending.pop_front();
                n_checked++;
                check_result(idx);
            end
        end
    end

    initial begin
        void'($urandom(32'h446c_6782));
        rst_n  = 1'b0;
        op_vd  = 1'b0;
        op_cmd = CMD_ADD;
        op1    = '0;
        op2    = '0;
        build_table();
        repeat (2) @(posedge clk);
        #(DRIVE_DLY) rst_n = 1'b1;
        @(negedge clk);
        if (!op_rdy || res_vld) begin
            errors++;
            $display("FAIL %0t: after reset op_rdy=%b res_vld=%b", $time, op_rdy, res_vld);
        end
        @(posedge clk);
        #(DRIVE_DLY);
        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(i);
        end
        op_vd = 1'b0;
        wait (n_checked == N_ENTRIES);
        repeat (4) @(posedge clk);              // Catch stray res_vld pulses
        $display("Checked %0d of %0d results, %0d errors", n_checked, N_ENTRIES, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d clock periods, %0d of %0d results seen",
                 WDOG_CYCLES, n_checked, N_ENTRIES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
